// File: Makefile
# Verilator build and run for the FIFO subsystem testbench

TOP := tb_fifo_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "^NO ERRORS$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_fifo_subsys.sv
// ---------------------------------------------------------------------------
// self-checking testbench for the FIFO subsystem
// a reference queue models the data path, assertions on the falling edge
// compare the DUT against it, the directed phases only steer the stimulus
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_fifo_subsys;

	localparam int DW              = fifo_pkg::DATA_WIDTH;
	localparam int CW              = fifo_pkg::COUNT_WIDTH;
	localparam int RW              = fifo_reg_pkg::REG_DATA_WIDTH;
	localparam int CAPACITY        = fifo_pkg::MEM_DEPTH + fifo_pkg::SKID_DEPTH;
	localparam int LATENCY         = 2 + fifo_pkg::DOUT_REGS_DEF;
	localparam int RANDOM_CYCLES   = 300;
	localparam int WATCHDOG_CYCLES = (2 * RANDOM_CYCLES + CAPACITY) * 8 + 400;

	logic          clk;
	logic          rst_n;
	logic [DW-1:0] s_data;
	logic          s_valid;
	logic          s_ready;
	logic [CW-1:0] s_free_count;
	logic [DW-1:0] m_data;
	logic          m_valid;
	logic          m_ready;
	logic [CW-1:0] m_data_count;
	logic          reg_wr;
	fifo_reg_pkg::reg_addr_e reg_addr;
	logic [RW-1:0] reg_wdata;
	logic [RW-1:0] reg_rdata;
	logic          almost_full;
	logic          almost_empty;
	logic          overflow;

	// reference model state
	logic [DW-1:0] ref_q [$];
	int            ref_size;
	logic [DW-1:0] ref_head;
	logic [CW-1:0] af_ref;
	logic [CW-1:0] ae_ref;
	logic          ovf_ref;
	logic          af_exp;
	logic          ae_exp;

	// handshakes seen on the falling edge, applied on the next rising edge
	logic          push_q;
	logic          pop_q;
	logic          refused_q;
	logic          reg_wr_q;
	fifo_reg_pkg::reg_addr_e reg_addr_q;
	logic [RW-1:0] reg_wdata_q;
	logic [DW-1:0] push_data_q;
	logic          wr_into_empty;

	int seed = 63694;
	int mismatch_count = 0;
	int failure_count = 0;
	int words_checked = 0;

	fifo_subsys i_fifo_subsys (
		.clk          (clk),
		.rst_n        (rst_n),
		.s_data       (s_data),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.s_free_count (s_free_count),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.m_data_count (m_data_count),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.almost_full  (almost_full),
		.almost_empty (almost_empty),
		.overflow     (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign wr_into_empty = s_valid && s_ready && (m_data_count == '0);

	// free count when every held word is still in memory
	function automatic int free_min(input int held);
		return (held >= fifo_pkg::MEM_DEPTH) ? 0 : fifo_pkg::MEM_DEPTH - held;
	endfunction

	// free count when the read stage holds as many words as it can
	function automatic int free_max(input int held);
		return (held <= fifo_pkg::SKID_DEPTH) ? fifo_pkg::MEM_DEPTH : CAPACITY - held;
	endfunction

	// ---------------------------------------------------------------------------
	// reference model
	// ---------------------------------------------------------------------------

	always @(negedge clk) begin
		push_q      = s_valid && s_ready;
		pop_q       = m_valid && m_ready;
		refused_q   = s_valid && !s_ready;
		reg_wr_q    = reg_wr;
		reg_addr_q  = reg_addr;
		reg_wdata_q = reg_wdata;
		push_data_q = s_data;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_q.delete();
			af_ref  = CW'(fifo_reg_pkg::AF_RESET);
			ae_ref  = CW'(fifo_reg_pkg::AE_RESET);
			ovf_ref = 1'b0;
			af_exp  = 1'b0;
			ae_exp  = 1'b1;
		end else begin
			// flags register the level held before this edge
			af_exp = (ref_q.size() >= int'(af_ref));
			ae_exp = (ref_q.size() <= int'(ae_ref));
			if (pop_q && ref_q.size() > 0) begin
				void'(ref_q.pop_front());
				words_checked++;
			end
			if (push_q) begin
				ref_q.push_back(push_data_q);
			end
			if (reg_wr_q && reg_addr_q == fifo_reg_pkg::REG_AF_LEVEL) begin
				af_ref = reg_wdata_q[CW-1:0];
			end
			if (reg_wr_q && reg_addr_q == fifo_reg_pkg::REG_AE_LEVEL) begin
				ae_ref = reg_wdata_q[CW-1:0];
			end
			// a refused write sets the bit even during a clear
			if (refused_q) begin
				ovf_ref = 1'b1;
			end else if (reg_wr_q && reg_addr_q == fifo_reg_pkg::REG_STATUS) begin
				ovf_ref = 1'b0;
			end
		end
		ref_size = ref_q.size();
		ref_head = (ref_q.size() > 0) ? ref_q[0] : '0;
	end

	// ---------------------------------------------------------------------------
	// checks, sampled mid-cycle where everything is settled
	// ---------------------------------------------------------------------------

	a_data: assert property (@(negedge clk) disable iff (!rst_n)
		(m_valid && m_ready) |-> (m_data == ref_head))
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: m_data = %h, expected %h", $time, m_data, ref_head);
	end

	a_count: assert property (@(negedge clk) disable iff (!rst_n)
		int'(m_data_count) == ref_size)
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: m_data_count = %0d, expected %0d",
			$time, m_data_count, ref_size);
	end

	a_hold: assert property (@(negedge clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
	else begin
		failure_count++;
		$display("m_data changed or m_valid dropped under back-pressure at %0t", $time);
	end

	a_fall_through: assert property (@(negedge clk) disable iff (!rst_n)
		$past(wr_into_empty, LATENCY + 1) |-> m_valid)
	else begin
		failure_count++;
		$display("word written into empty FIFO not presented in time at %0t", $time);
	end

	a_no_early_valid: assert property (@(negedge clk) disable iff (!rst_n)
		($past(wr_into_empty) || $past(wr_into_empty, LATENCY)) |-> !m_valid)
	else begin
		failure_count++;
		$display("m_valid rose too early after a write into empty FIFO at %0t", $time);
	end

	a_full: assert property (@(negedge clk) disable iff (!rst_n)
		(ref_size == CAPACITY) |-> (!s_ready && s_free_count == '0))
	else begin
		failure_count++;
		$display("FIFO holds all words but still accepts writes at %0t", $time);
	end

	a_ready_free: assert property (@(negedge clk) disable iff (!rst_n)
		s_ready == (s_free_count != '0))
	else begin
		failure_count++;
		$display("s_ready does not follow the free memory count at %0t", $time);
	end

	a_free_count: assert property (@(negedge clk) disable iff (!rst_n)
		(int'(s_free_count) >= free_min(ref_size)) &&
		(int'(s_free_count) <= free_max(ref_size)))
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: s_free_count = %0d, expected %0d to %0d",
			$time, s_free_count, free_min(ref_size), free_max(ref_size));
	end

	a_almost_full: assert property (@(negedge clk) disable iff (!rst_n)
		almost_full == af_exp)
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: almost_full = %b, expected %b", $time, almost_full,
			af_exp);
	end

	a_almost_empty: assert property (@(negedge clk) disable iff (!rst_n)
		almost_empty == ae_exp)
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: almost_empty = %b, expected %b", $time, almost_empty,
			ae_exp);
	end

	a_overflow: assert property (@(negedge clk) disable iff (!rst_n)
		overflow == ovf_ref)
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: overflow = %b, expected %b", $time, overflow, ovf_ref);
	end

	a_count_reg: assert property (@(negedge clk) disable iff (!rst_n)
		(reg_addr == fifo_reg_pkg::REG_COUNT) |->
			((reg_rdata[7:0] == 8'(ref_size)) &&
			(int'(reg_rdata[15:8]) >= free_min(ref_size)) &&
			(int'(reg_rdata[15:8]) <= free_max(ref_size))))
	else begin
		mismatch_count++;
		$display("Mismatch at %0t: reg_rdata count = %0d free %0d, expected %0d free %0d to %0d",
			$time, reg_rdata[7:0], reg_rdata[15:8], ref_size,
			free_min(ref_size), free_max(ref_size));
	end

	// ---------------------------------------------------------------------------
	// stimulus tasks
	// ---------------------------------------------------------------------------

	task automatic write_reg(input fifo_reg_pkg::reg_addr_e addr, input logic [RW-1:0] data);
		@(posedge clk);
		#1;
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_wr   = 1'b0;
		reg_addr = fifo_reg_pkg::REG_COUNT;
	endtask

	task automatic expect_reg(input fifo_reg_pkg::reg_addr_e addr, input logic [RW-1:0] expected);
		@(posedge clk);
		#1;
		reg_addr = addr;
		@(negedge clk);
		assert (reg_rdata == expected)
		else begin
			mismatch_count++;
			$display("Mismatch at %0t: reg_rdata[%s] = %h, expected %h",
				$time, addr.name(), reg_rdata, expected);
		end
		@(posedge clk);
		#1;
		reg_addr = fifo_reg_pkg::REG_COUNT;
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		assert (!m_valid && s_ready && almost_empty && !almost_full && !overflow)
		else begin
			failure_count++;
			$display("outputs not in reset state at %0t: m_valid %b s_ready %b ae %b af %b ovf %b",
				$time, m_valid, s_ready, almost_empty, almost_full, overflow);
		end
		expect_reg(fifo_reg_pkg::REG_AF_LEVEL, RW'(fifo_reg_pkg::AF_RESET));
		expect_reg(fifo_reg_pkg::REG_AE_LEVEL, RW'(fifo_reg_pkg::AE_RESET));
	endtask

	task automatic drain_all();
		int waited;
		@(posedge clk);
		#1;
		s_valid = 1'b0;
		m_ready = 1'b1;
		waited  = 0;
		@(negedge clk);
		while (ref_size != 0 && waited < CAPACITY * 4) begin
			@(negedge clk);
			waited++;
		end
		if (ref_size != 0) begin
			failure_count++;
			$display("FIFO did not drain, %0d words left at %0t", ref_size, $time);
		end
	endtask

	task automatic check_latency();
		int waited;
		@(posedge clk);
		#1;
		m_ready = 1'b0;
		s_valid = 1'b1;
		s_data  = 8'h5a;
		@(posedge clk);
		#1;
		s_valid = 1'b0;
		waited  = 0;
		@(negedge clk);
		while (!m_valid && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (!m_valid) begin
			failure_count++;
			$display("single word never appeared on the output");
		end
		// head must stay put while the sink stalls
		repeat (4) @(posedge clk);
		drain_all();
	endtask

	task automatic run_random(input int cycles, input bit slow_read);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#1;
			s_valid = ($random(seed) & 3) != 0;
			s_data  = 8'($random(seed));
			if (slow_read) begin
				m_ready = ($random(seed) & 3) == 0;
			end else begin
				m_ready = ($random(seed) & 1) != 0;
			end
		end
	endtask

	task automatic check_capacity();
		int accepted;
		int stalled;
		accepted = 0;
		stalled  = 0;
		@(posedge clk);
		#1;
		m_ready = 1'b0;
		s_valid = 1'b1;
		s_data  = 8'($random(seed));
		for (int i = 0; i < 4 * CAPACITY && stalled < 4; i++) begin
			@(negedge clk);
			if (s_ready) begin
				accepted++;
				stalled = 0;
			end else begin
				stalled++;
			end
			@(posedge clk);
			#1;
			s_data = 8'($random(seed));
		end
		assert (accepted == CAPACITY)
		else begin
			mismatch_count++;
			$display("Mismatch at %0t: accepted words = %0d, expected %0d",
				$time, accepted, CAPACITY);
		end
		// memory full, so the free field reads zero
		expect_reg(fifo_reg_pkg::REG_COUNT, {8'd0, 8'(CAPACITY)});
		expect_reg(fifo_reg_pkg::REG_STATUS, RW'(1));
		@(posedge clk);
		#1;
		s_valid = 1'b0;
		write_reg(fifo_reg_pkg::REG_STATUS, '0);
		expect_reg(fifo_reg_pkg::REG_STATUS, '0);
		drain_all();
	endtask

	// ---------------------------------------------------------------------------
	// test sequence and watchdog
	// ---------------------------------------------------------------------------

	initial begin
		rst_n     = 1'b0;
		s_valid   = 1'b0;
		s_data    = '0;
		m_ready   = 1'b0;
		reg_wr    = 1'b0;
		reg_addr  = fifo_reg_pkg::REG_COUNT;
		reg_wdata = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		check_reset_state();
		check_latency();
		run_random(RANDOM_CYCLES, 1'b0);
		drain_all();
		check_capacity();

		write_reg(fifo_reg_pkg::REG_AF_LEVEL, RW'(5));
		write_reg(fifo_reg_pkg::REG_AE_LEVEL, RW'(3));
		expect_reg(fifo_reg_pkg::REG_AF_LEVEL, RW'(5));
		expect_reg(fifo_reg_pkg::REG_AE_LEVEL, RW'(3));
		run_random(RANDOM_CYCLES, 1'b1);
		drain_all();
		write_reg(fifo_reg_pkg::REG_STATUS, '0);
		expect_reg(fifo_reg_pkg::REG_STATUS, '0);

		$display("summary: %0d mismatches, %0d other failures, %0d words checked",
			mismatch_count, failure_count, words_checked);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, test did not complete", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sources.f
src/fifo_pkg.sv
src/fifo_reg_pkg.sv
src/fifo_mem.sv
src/fifo_read_fwft.sv
src/fifo_fwft.sv
src/fifo_level_regs.sv
src/fifo_subsys.sv
dv/tb_fifo_subsys.sv

// File: src/fifo_fwft.sv
// -------------------------------------------------------------------------
// first-word fall-through FIFO with valid/ready ports on both sides
// joins the ring memory core and the prefetching read stage
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_fwft #(
	parameter int DOUT_REGS = fifo_pkg::DOUT_REGS_DEF
) (
	input  logic                             clk,
	input  logic                             rst_n,

	input  logic [fifo_pkg::DATA_WIDTH-1:0]  s_data,
	input  logic                             s_valid,
	output logic                             s_ready,
	output logic [fifo_pkg::COUNT_WIDTH-1:0] s_free_count,

	output logic [fifo_pkg::DATA_WIDTH-1:0]  m_data,
	output logic                             m_valid,
	input  logic                             m_ready,
	output logic [fifo_pkg::COUNT_WIDTH-1:0] m_data_count
);

	logic                             wr_en;
	logic                             rd_en;
	logic                             rd_regcke;
	logic [fifo_pkg::DATA_WIDTH-1:0]  rd_data;
	logic                             full;
	logic                             empty;
	logic [fifo_pkg::COUNT_WIDTH-1:0] data_count;

	// write side accepts whenever the ring has room
	assign s_ready = !full;
	assign wr_en   = s_valid && s_ready;

	fifo_mem #(
		.DOUT_REGS (DOUT_REGS)
	) i_fifo_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_data    (s_data),
		.rd_en      (rd_en),
		.rd_regcke  (rd_regcke),
		.rd_data    (rd_data),
		.full       (full),
		.empty      (empty),
		.free_count (s_free_count),
		.data_count (data_count)
	);

	fifo_read_fwft #(
		.DOUT_REGS (DOUT_REGS)
	) i_fifo_read_fwft (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_en     (rd_en),
		.rd_regcke (rd_regcke),
		.rd_data   (rd_data),
		.rd_empty  (empty),
		.rd_count  (data_count),
		.m_data    (m_data),
		.m_valid   (m_valid),
		.m_ready   (m_ready),
		.m_count   (m_data_count)
	);

endmodule

// File: src/fifo_level_regs.sv
// -------------------------------------------------------------------------
// level registers beside the FIFO
// programmable almost flags, sticky overflow and count readback
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_level_regs (
	input  logic                                    clk,
	input  logic                                    rst_n,

	input  logic                                    reg_wr,
	input  fifo_reg_pkg::reg_addr_e                 reg_addr,
	input  logic [fifo_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
	output logic [fifo_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata,

	input  logic [fifo_pkg::COUNT_WIDTH-1:0]        data_count,
	input  logic [fifo_pkg::COUNT_WIDTH-1:0]        free_count,
	input  logic                                    s_valid,
	input  logic                                    s_ready,

	output logic                                    almost_full,
	output logic                                    almost_empty,
	output logic                                    overflow
);

	localparam int CW = fifo_pkg::COUNT_WIDTH;
	localparam int FW = fifo_reg_pkg::COUNT_FIELD_WIDTH;

	logic [CW-1:0] af_level;
	logic [CW-1:0] ae_level;

	// -----------------------------------------------------------------------
	// register writes and status
	// -----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			af_level <= CW'(fifo_reg_pkg::AF_RESET);
			ae_level <= CW'(fifo_reg_pkg::AE_RESET);
			overflow <= 1'b0;
		end else begin
			if (reg_wr && reg_addr == fifo_reg_pkg::REG_AF_LEVEL) begin
				af_level <= reg_wdata[CW-1:0];
			end
			if (reg_wr && reg_addr == fifo_reg_pkg::REG_AE_LEVEL) begin
				ae_level <= reg_wdata[CW-1:0];
			end
			// a refused write in the same cycle wins over the clear
			if (s_valid && !s_ready) begin
				overflow <= 1'b1;
			end else if (reg_wr && reg_addr == fifo_reg_pkg::REG_STATUS) begin
				overflow <= 1'b0;
			end
		end
	end

	// flags follow the count one cycle late
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			almost_full  <= 1'b0;
			almost_empty <= 1'b1;
		end else begin
			almost_full  <= (data_count >= af_level);
			almost_empty <= (data_count <= ae_level);
		end
	end

	// -----------------------------------------------------------------------
	// readback
	// -----------------------------------------------------------------------

	always_comb begin
		reg_rdata = '0;
		case (reg_addr)
			fifo_reg_pkg::REG_AF_LEVEL: reg_rdata[CW-1:0] = af_level;
			fifo_reg_pkg::REG_AE_LEVEL: reg_rdata[CW-1:0] = ae_level;
			fifo_reg_pkg::REG_STATUS: begin
				reg_rdata[fifo_reg_pkg::STATUS_OVF_BIT] = overflow;
			end
			fifo_reg_pkg::REG_COUNT: begin
				reg_rdata[FW-1:0] = FW'(data_count);
				reg_rdata[fifo_reg_pkg::COUNT_FREE_LSB +: FW] = FW'(free_count);
			end
			default: reg_rdata = '0;
		endcase
	end

endmodule

// File: src/fifo_mem.sv
// -------------------------------------------------------------------------
// ring memory core of the FIFO with pointers, flags and counts
// read data is registered, with an optional second output register
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_mem #(
	parameter int DOUT_REGS = fifo_pkg::DOUT_REGS_DEF
) (
	input  logic                            clk,
	input  logic                            rst_n,

	input  logic                            wr_en,
	input  logic [fifo_pkg::DATA_WIDTH-1:0] wr_data,

	input  logic                            rd_en,
	input  logic                            rd_regcke,
	output logic [fifo_pkg::DATA_WIDTH-1:0] rd_data,

	output logic                            full,
	output logic                            empty,
	output logic [fifo_pkg::COUNT_WIDTH-1:0] free_count,
	output logic [fifo_pkg::COUNT_WIDTH-1:0] data_count
);

	localparam int DW = fifo_pkg::DATA_WIDTH;
	localparam int PW = fifo_pkg::PTR_WIDTH;
	localparam int CW = fifo_pkg::COUNT_WIDTH;

	logic [DW-1:0] mem [fifo_pkg::MEM_DEPTH];

	// pointers carry one wrap bit above the address
	logic [PW:0]   wr_ptr;
	logic [PW:0]   rd_ptr;
	logic [PW:0]   ptr_diff;
	logic [DW-1:0] rd_q;

	// -----------------------------------------------------------------------
	// pointers
	// -----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// same address, wrap bits differ when full
	assign empty      = (wr_ptr == rd_ptr);
	assign full       = (wr_ptr == {~rd_ptr[PW], rd_ptr[PW-1:0]});
	assign ptr_diff   = wr_ptr - rd_ptr;
	assign data_count = {{(CW-PW-1){1'b0}}, ptr_diff};
	assign free_count = CW'(fifo_pkg::MEM_DEPTH) - data_count;

	// -----------------------------------------------------------------------
	// storage and read port
	// -----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[PW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_q <= mem[rd_ptr[PW-1:0]];
		end
	end

	generate
		if (DOUT_REGS > 0) begin : g_out_reg
			logic [DW-1:0] out_q;

			// second stage loads when the first holds a fresh word
			always_ff @(posedge clk) begin
				if (rd_regcke) begin
					out_q <= rd_q;
				end
			end
			assign rd_data = out_q;
		end else begin : g_no_out_reg
			assign rd_data = rd_q;
		end
	endgenerate

	// the write and read sides are gated outside this module
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full);
	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> !empty);

endmodule

// File: src/fifo_pkg.sv
// -------------------------------------------------------------------------
// datapath constants for the fall-through FIFO subsystem
// referenced by scoped name from the FIFO modules and the testbench
// -------------------------------------------------------------------------

package fifo_pkg;

	// word width of the data path
	localparam int DATA_WIDTH = 8;

	// memory address width and the resulting ring depth
	localparam int PTR_WIDTH = 4;
	localparam int MEM_DEPTH = 1 << PTR_WIDTH;

	// default number of extra output registers behind the RAM
	localparam int DOUT_REGS_DEF = 0;

	// read-stage buffer, read latency plus one
	localparam int SKID_DEPTH = 2 + DOUT_REGS_DEF;

	// -----------------------------------------------------------------------
	// counts and thresholds
	// -----------------------------------------------------------------------

	// must hold MEM_DEPTH + SKID_DEPTH
	localparam int COUNT_WIDTH = 6;

endpackage

// File: src/fifo_read_fwft.sv
// -------------------------------------------------------------------------
// fall-through read stage behind the ring memory
// prefetches words into a skid buffer and presents the oldest on m_data
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_read_fwft #(
	parameter int DOUT_REGS = fifo_pkg::DOUT_REGS_DEF
) (
	input  logic                             clk,
	input  logic                             rst_n,

	output logic                             rd_en,
	output logic                             rd_regcke,
	input  logic [fifo_pkg::DATA_WIDTH-1:0]  rd_data,
	input  logic                             rd_empty,
	input  logic [fifo_pkg::COUNT_WIDTH-1:0] rd_count,

	output logic [fifo_pkg::DATA_WIDTH-1:0]  m_data,
	output logic                             m_valid,
	input  logic                             m_ready,
	output logic [fifo_pkg::COUNT_WIDTH-1:0] m_count
);

	localparam int DW     = fifo_pkg::DATA_WIDTH;
	localparam int CW     = fifo_pkg::COUNT_WIDTH;
	localparam int DEPTH  = fifo_pkg::SKID_DEPTH;
	localparam int RD_LAT = 1 + DOUT_REGS;
	localparam int BUF_AW = $clog2(DEPTH);

	logic [DW-1:0]     buf_mem [DEPTH];
	logic [BUF_AW-1:0] wr_idx;
	logic [BUF_AW-1:0] rd_idx;
	logic [CW-1:0]     buf_cnt;
	logic [CW-1:0]     inflight_cnt;
	// one bit per read still travelling through the RAM pipe
	logic [RD_LAT-1:0] flight;
	logic              arrive;
	logic              pop;

	function automatic logic [BUF_AW-1:0] next_idx(input logic [BUF_AW-1:0] idx);
		if (idx == BUF_AW'(DEPTH - 1)) begin
			return '0;
		end
		return idx + 1'b1;
	endfunction

	always_comb begin
		inflight_cnt = '0;
		for (int i = 0; i < RD_LAT; i++) begin
			inflight_cnt = inflight_cnt + CW'(flight[i]);
		end
	end

	// room must remain for every word already requested
	assign rd_en     = !rd_empty && ((buf_cnt + inflight_cnt) < CW'(DEPTH));
	assign rd_regcke = flight[0];
	assign arrive    = flight[RD_LAT-1];
	assign pop       = m_valid && m_ready;

	assign m_valid = (buf_cnt != '0);
	assign m_data  = buf_mem[rd_idx];
	assign m_count = rd_count + buf_cnt + inflight_cnt;

	// -----------------------------------------------------------------------
	// pipe tracking and buffer control
	// -----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flight  <= '0;
			wr_idx  <= '0;
			rd_idx  <= '0;
			buf_cnt <= '0;
		end else begin
			flight <= (flight << 1) | RD_LAT'(rd_en);
			if (arrive) begin
				wr_idx <= next_idx(wr_idx);
			end
			if (pop) begin
				rd_idx <= next_idx(rd_idx);
			end
			case ({arrive, pop})
				2'b10:   buf_cnt <= buf_cnt + 1'b1;
				2'b01:   buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arrive) begin
			buf_mem[wr_idx] <= rd_data;
		end
	end

	// head word must not move under back-pressure
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

// File: src/fifo_reg_pkg.sv
// -------------------------------------------------------------------------
// register map of the FIFO level block
// addresses, field layout and reset values of the thresholds
// -------------------------------------------------------------------------

package fifo_reg_pkg;

	localparam int REG_ADDR_WIDTH = 2;
	localparam int REG_DATA_WIDTH = 16;

	// register addresses
	typedef enum logic [REG_ADDR_WIDTH-1:0] {
		REG_AF_LEVEL = 2'd0,
		REG_AE_LEVEL = 2'd1,
		REG_STATUS   = 2'd2,
		REG_COUNT    = 2'd3
	} reg_addr_e;

	// status register layout
	localparam int STATUS_OVF_BIT = 0;

	// count register layout, data count low byte and free count high byte
	localparam int COUNT_FIELD_WIDTH = 8;
	localparam int COUNT_FREE_LSB    = 8;

	// threshold reset values
	localparam int AF_RESET = 14;
	localparam int AE_RESET = 2;

endpackage

// File: src/fifo_subsys.sv
// -------------------------------------------------------------------------
// top level of the FIFO subsystem
// FWFT FIFO on the data ports, level registers on a strobe port
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_subsys (
	input  logic                                    clk,
	input  logic                                    rst_n,

	// write side
	input  logic [fifo_pkg::DATA_WIDTH-1:0]         s_data,
	input  logic                                    s_valid,
	output logic                                    s_ready,
	output logic [fifo_pkg::COUNT_WIDTH-1:0]        s_free_count,

	// read side
	output logic [fifo_pkg::DATA_WIDTH-1:0]         m_data,
	output logic                                    m_valid,
	input  logic                                    m_ready,
	output logic [fifo_pkg::COUNT_WIDTH-1:0]        m_data_count,

	// register port
	input  logic                                    reg_wr,
	input  fifo_reg_pkg::reg_addr_e                 reg_addr,
	input  logic [fifo_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
	output logic [fifo_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata,

	output logic                                    almost_full,
	output logic                                    almost_empty,
	output logic                                    overflow
);

	fifo_fwft #(
		.DOUT_REGS (fifo_pkg::DOUT_REGS_DEF)
	) i_fifo_fwft (
		.clk          (clk),
		.rst_n        (rst_n),
		.s_data       (s_data),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.s_free_count (s_free_count),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.m_data_count (m_data_count)
	);

	// flags watch the total word count, including the read stage
	fifo_level_regs i_fifo_level_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.data_count   (m_data_count),
		.free_count   (s_free_count),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.almost_full  (almost_full),
		.almost_empty (almost_empty),
		.overflow     (overflow)
	);

endmodule
